/* rtl/rt_pkg.sv */
package rt_pkg;

    // ====================
    // basic types
    // ====================

    // one ROM data word
    typedef logic [31:0] word_t;
    // byte address into the routing image
    typedef logic [31:0] byte_addr_t;
    typedef logic [5:0]  host_idx_t;
    typedef logic [3:0]  switch_id_t;
    // words in one burst, 0 to 8
    typedef logic [3:0]  burst_len_t;

    // ====================
    // image format
    // ====================

    // word 0 of each header, ASCII "HOST" and "SWCH"
    localparam word_t HOST_MAGIC = 32'h484F_5354;
    localparam word_t SWCH_MAGIC = 32'h5357_4348;

    localparam byte_addr_t HEADER_BYTES     = 32'd16;
    localparam byte_addr_t HOST_ENTRY_BYTES = 32'd32;
    localparam byte_addr_t PATH_ENTRY_BYTES = 32'd16;

    localparam burst_len_t HEADER_WORDS     = 4'd4;
    localparam burst_len_t HOST_ENTRY_WORDS = 4'd8;
    localparam burst_len_t PATH_ENTRY_WORDS = 4'd4;

    // ====================
    // decoded entries
    // ====================

    // words 0, 1 and 3 of a host entry
    // word 3 carries port low and qp high
    typedef struct packed {
        word_t       ip;
        word_t       switch_id;
        logic [15:0] port;
        logic [15:0] qp;
    } host_entry_t;

    // one path entry, four words
    typedef struct packed {
        // byte 0 of word 0 nonzero
        logic        valid;
        logic [7:0]  next_hop_switch;
        logic [15:0] out_port;
        logic [15:0] out_qp;
        logic [15:0] distance;
        word_t       next_hop_ip;
        logic [15:0] next_hop_port;
        logic [15:0] next_hop_qp;
    } path_entry_t;

endpackage

/* rtl/apb_pkg.sv */
package apb_pkg;

    typedef logic [7:0] apb_addr_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        apb_addr_t   paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    // ====================
    // register map
    // ====================
    localparam apb_addr_t REG_CTRL         = 8'h00;
    localparam apb_addr_t REG_STATUS       = 8'h04;
    localparam apb_addr_t REG_QUERY        = 8'h08;
    localparam apb_addr_t REG_HOST_COUNT   = 8'h0C;
    localparam apb_addr_t REG_MAX_SWITCH   = 8'h10;
    localparam apb_addr_t REG_HOST_IP      = 8'h14;
    localparam apb_addr_t REG_HOST_SWITCH  = 8'h18;
    localparam apb_addr_t REG_HOST_PORT_QP = 8'h1C;
    localparam apb_addr_t REG_PATH_W0      = 8'h20;
    localparam apb_addr_t REG_PATH_W1      = 8'h24;
    localparam apb_addr_t REG_PATH_NH_IP   = 8'h28;
    localparam apb_addr_t REG_PATH_W3      = 8'h2C;

endpackage

/* rtl/rt_word_reader.sv */
module rt_word_reader #(
    parameter int ROM_ADDR_W = 12
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  burst_start,
    input  rt_pkg::byte_addr_t    base,
    input  rt_pkg::burst_len_t    len,
    output logic [ROM_ADDR_W-1:0] mem_addr,
    input  rt_pkg::word_t         mem_data,
    output logic                  word_valid,
    output rt_pkg::burst_len_t    word_idx,
    output rt_pkg::word_t         word,
    output logic                  done
);
    import rt_pkg::*;

    // issue side, one address per cycle
    logic       issuing;
    burst_len_t iss_cnt;
    burst_len_t len_q;
    // return side, one cycle behind
    logic       rd_pend;
    burst_len_t ret_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issuing  <= 1'b0;
            iss_cnt  <= '0;
            len_q    <= '0;
            mem_addr <= '0;
        end else if (burst_start) begin
            issuing  <= 1'b1;
            iss_cnt  <= 4'd1;
            len_q    <= len;
            mem_addr <= base[ROM_ADDR_W-1:0];
        end else if (issuing) begin
            if (iss_cnt == len_q) begin
                issuing <= 1'b0;
            end else begin
                iss_cnt  <= iss_cnt + 4'd1;
                mem_addr <= mem_addr + ROM_ADDR_W'(4);
            end
        end
    end

    // the ROM answers one cycle after the address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
            ret_idx <= '0;
        end else begin
            rd_pend <= issuing;
            if (burst_start) begin
                ret_idx <= '0;
            end else if (rd_pend) begin
                ret_idx <= ret_idx + 4'd1;
            end
        end
    end

    assign word_valid = rd_pend;
    assign word_idx   = ret_idx;
    assign word       = mem_data;
    assign done       = rd_pend && (ret_idx == len_q - 4'd1);

    // walker must wait for done before the next burst
    assert property (@(posedge clk) disable iff (!rst_n)
        burst_start |-> !issuing && !rd_pend)
        else $error("burst_start while a burst is in flight");

endmodule

/* rtl/rt_table_walker.sv */
module rt_table_walker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_start,
    input  logic                host_req,
    input  logic                path_req,
    input  rt_pkg::host_idx_t   query_host,
    input  rt_pkg::switch_id_t  query_src,
    input  rt_pkg::switch_id_t  query_dst,
    output logic                busy,
    output logic                tables_valid,
    output logic                parse_error,
    output rt_pkg::word_t       host_count,
    output rt_pkg::word_t       max_switch_id,
    output logic                host_done,
    output rt_pkg::host_entry_t host_entry,
    output logic                path_done,
    output rt_pkg::path_entry_t path_entry,
    output logic                lookup_miss,
    output logic                burst_start,
    output rt_pkg::byte_addr_t  base,
    output rt_pkg::burst_len_t  len,
    input  logic                word_valid,
    input  rt_pkg::burst_len_t  word_idx,
    input  rt_pkg::word_t       word,
    input  logic                done
);
    import rt_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HOST_HDR,
        ST_SW_HDR,
        ST_READY,
        ST_HOST_ENT,
        ST_PATH_ENT
    } state_t;

    state_t     state;
    logic       accept;
    logic       host_hit;
    byte_addr_t sw_base;
    byte_addr_t sw_base_nxt;
    byte_addr_t launch_base;
    burst_len_t launch_len;
    // only words 0..3 are decoded in every record
    word_t      buf_q [0:3];
    word_t      cur_w [0:3];

    assign accept   = (state == ST_IDLE) || (state == ST_READY);
    assign busy     = !accept;
    assign host_hit = (state == ST_READY) && (word_t'(query_host) < host_count);

    // buffered words with the word arriving this cycle merged in
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            cur_w[i] = (word_valid && word_idx == burst_len_t'(i)) ? word : buf_q[i];
        end
    end

    assign sw_base_nxt = HEADER_BYTES + cur_w[1] * HOST_ENTRY_BYTES;

    // ====================
    // burst address rules
    // ====================
    always_comb begin
        launch_base = '0;
        launch_len  = HEADER_WORDS;
        if (state == ST_HOST_HDR) begin
            launch_base = sw_base_nxt;
        end else if (!load_start && host_req) begin
            launch_base = HEADER_BYTES + byte_addr_t'(query_host) * HOST_ENTRY_BYTES;
            launch_len  = HOST_ENTRY_WORDS;
        end else if (!load_start) begin
            launch_base = sw_base + HEADER_BYTES
                        + (byte_addr_t'(query_src) * (max_switch_id + 32'd1)
                           + byte_addr_t'(query_dst)) * PATH_ENTRY_BYTES;
            launch_len  = PATH_ENTRY_WORDS;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            burst_start   <= 1'b0;
            tables_valid  <= 1'b0;
            parse_error   <= 1'b0;
            host_count    <= '0;
            max_switch_id <= '0;
            sw_base       <= '0;
            host_done     <= 1'b0;
            path_done     <= 1'b0;
            lookup_miss   <= 1'b0;
        end else begin
            burst_start <= 1'b0;
            host_done   <= 1'b0;
            path_done   <= 1'b0;
            lookup_miss <= 1'b0;
            case (state)
                ST_IDLE, ST_READY: begin
                    if (load_start) begin
                        state        <= ST_HOST_HDR;
                        burst_start  <= 1'b1;
                        tables_valid <= 1'b0;
                        parse_error  <= 1'b0;
                    end else if (host_req) begin
                        if (host_hit) begin
                            state       <= ST_HOST_ENT;
                            burst_start <= 1'b1;
                        end else begin
                            lookup_miss <= 1'b1;
                        end
                    end else if (path_req) begin
                        if (state == ST_READY) begin
                            state       <= ST_PATH_ENT;
                            burst_start <= 1'b1;
                        end else begin
                            lookup_miss <= 1'b1;
                        end
                    end
                end
                ST_HOST_HDR: begin
                    if (done && cur_w[0] == HOST_MAGIC) begin
                        host_count  <= cur_w[1];
                        sw_base     <= sw_base_nxt;
                        state       <= ST_SW_HDR;
                        burst_start <= 1'b1;
                    end else if (done) begin
                        parse_error <= 1'b1;
                        state       <= ST_IDLE;
                    end
                end
                ST_SW_HDR: begin
                    if (done && cur_w[0] == SWCH_MAGIC) begin
                        max_switch_id <= cur_w[2];
                        tables_valid  <= 1'b1;
                        state         <= ST_READY;
                    end else if (done) begin
                        parse_error <= 1'b1;
                        state       <= ST_IDLE;
                    end
                end
                ST_HOST_ENT: begin
                    if (done) begin
                        host_done <= 1'b1;
                        state     <= ST_READY;
                    end
                end
                ST_PATH_ENT: begin
                    if (done) begin
                        path_done <= 1'b1;
                        state     <= ST_READY;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // base and len only matter in the cycle of burst_start
    always_ff @(posedge clk) begin
        base <= launch_base;
        len  <= launch_len;
        if (word_valid && word_idx < 4'd4) begin
            buf_q[word_idx[1:0]] <= word;
        end
        if (state == ST_HOST_ENT && done) begin
            host_entry <= '{ip: cur_w[0], switch_id: cur_w[1],
                            port: cur_w[3][15:0], qp: cur_w[3][31:16]};
        end
        if (state == ST_PATH_ENT && done) begin
            path_entry <= '{valid: cur_w[0][7:0] != 8'h00,
                            next_hop_switch: cur_w[0][15:8],
                            out_port: cur_w[0][31:16],
                            out_qp: cur_w[1][15:0],
                            distance: cur_w[1][31:16],
                            next_hop_ip: cur_w[2],
                            next_hop_port: cur_w[3][15:0],
                            next_hop_qp: cur_w[3][31:16]};
        end
    end

    // reader done and completion pulses never coincide
    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({done, host_done, path_done, lookup_miss}))
        else $error("more than one done pulse in a cycle");

endmodule

/* rtl/rt_regs.sv */
module rt_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  apb_pkg::apb_req_t   apb_req,
    output apb_pkg::apb_rsp_t   apb_rsp,
    output logic                load_start,
    output logic                host_req,
    output logic                path_req,
    output rt_pkg::host_idx_t   query_host,
    output rt_pkg::switch_id_t  query_src,
    output rt_pkg::switch_id_t  query_dst,
    input  logic                busy,
    input  logic                tables_valid,
    input  logic                parse_error,
    input  rt_pkg::word_t       host_count,
    input  rt_pkg::word_t       max_switch_id,
    input  logic                host_done,
    input  rt_pkg::host_entry_t host_entry,
    input  logic                path_done,
    input  rt_pkg::path_entry_t path_entry,
    input  logic                lookup_miss
);
    import apb_pkg::*;
    import rt_pkg::*;

    logic        access;
    logic        wr_ok;
    logic        rd_ok;
    logic        ctrl_wr;
    logic        query_wr;
    logic [31:0] rdata;
    // sticky completion bits
    logic        host_done_s;
    logic        path_done_s;
    logic        miss_s;
    host_entry_t host_q;
    path_entry_t path_q;

    // zero wait states, every access ends in its access phase
    assign access   = apb_req.psel && apb_req.penable;
    assign wr_ok    = (apb_req.paddr == REG_CTRL) || (apb_req.paddr == REG_QUERY);
    assign ctrl_wr  = access && apb_req.pwrite && (apb_req.paddr == REG_CTRL);
    assign query_wr = access && apb_req.pwrite && (apb_req.paddr == REG_QUERY);

    // ====================
    // control and query
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_start  <= 1'b0;
            host_req    <= 1'b0;
            path_req    <= 1'b0;
            query_host  <= '0;
            query_src   <= '0;
            query_dst   <= '0;
            host_done_s <= 1'b0;
            path_done_s <= 1'b0;
            miss_s      <= 1'b0;
        end else begin
            load_start <= ctrl_wr && apb_req.pwdata[0];
            host_req   <= ctrl_wr && apb_req.pwdata[1];
            path_req   <= ctrl_wr && apb_req.pwdata[2];
            if (query_wr) begin
                query_host <= apb_req.pwdata[5:0];
                query_src  <= apb_req.pwdata[11:8];
                query_dst  <= apb_req.pwdata[15:12];
            end
            // a pulse wins over the clear
            host_done_s <= host_done || (host_done_s && !ctrl_wr);
            path_done_s <= path_done || (path_done_s && !ctrl_wr);
            miss_s      <= lookup_miss || (miss_s && !ctrl_wr);
        end
    end

    always_ff @(posedge clk) begin
        if (host_done) begin
            host_q <= host_entry;
        end
        if (path_done) begin
            path_q <= path_entry;
        end
    end

    // ====================
    // read mux
    // ====================
    always_comb begin
        rd_ok = 1'b1;
        rdata = '0;
        case (apb_req.paddr)
            REG_CTRL:         rdata = '0;
            REG_STATUS:       rdata = {26'd0, miss_s, path_done_s, host_done_s,
                                       parse_error, tables_valid, busy};
            REG_QUERY:        rdata = {16'd0, query_dst, query_src, 2'd0, query_host};
            REG_HOST_COUNT:   rdata = host_count;
            REG_MAX_SWITCH:   rdata = max_switch_id;
            REG_HOST_IP:      rdata = host_q.ip;
            REG_HOST_SWITCH:  rdata = host_q.switch_id;
            REG_HOST_PORT_QP: rdata = {host_q.qp, host_q.port};
            REG_PATH_W0:      rdata = {path_q.out_port, path_q.next_hop_switch,
                                       7'd0, path_q.valid};
            REG_PATH_W1:      rdata = {path_q.distance, path_q.out_qp};
            REG_PATH_NH_IP:   rdata = path_q.next_hop_ip;
            REG_PATH_W3:      rdata = {path_q.next_hop_qp, path_q.next_hop_port};
            default:          rd_ok = 1'b0;
        endcase
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pslverr = access && (apb_req.pwrite ? !wr_ok : !rd_ok);

    // access phase always follows a setup phase
    assert property (@(posedge clk) disable iff (!rst_n)
        apb_req.penable |-> apb_req.psel && $past(apb_req.psel))
        else $error("penable without a setup phase");

endmodule

/* rtl/rt_reader_top.sv */
module rt_reader_top #(
    parameter int ROM_ADDR_W = 12
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  apb_pkg::apb_req_t     apb_req,
    output apb_pkg::apb_rsp_t     apb_rsp,
    output logic                  pready,
    output logic [ROM_ADDR_W-1:0] mem_addr,
    input  rt_pkg::word_t         mem_data
);
    import rt_pkg::*;

    // register block to walker
    logic        load_start, host_req, path_req;
    host_idx_t   query_host;
    switch_id_t  query_src, query_dst;
    logic        busy, tables_valid, parse_error;
    word_t       host_count, max_switch_id;
    logic        host_done, path_done, lookup_miss;
    host_entry_t host_entry;
    path_entry_t path_entry;
    // walker to word reader
    logic        burst_start, word_valid, done;
    byte_addr_t  base;
    burst_len_t  len, word_idx;
    word_t       word;

    assign pready = 1'b1;

    rt_regs regs_i (.*);

    rt_table_walker walker_i (.*);

    rt_word_reader #(
        .ROM_ADDR_W (ROM_ADDR_W)
    ) reader_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .burst_start (burst_start),
        .base        (base),
        .len         (len),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data),
        .word_valid  (word_valid),
        .word_idx    (word_idx),
        .word        (word),
        .done        (done)
    );

endmodule

/* dv/rt_rom_model.sv */
module rt_rom_model #(
    parameter int ROM_ADDR_W = 12
) (
    input  logic                  clk,
    // byte address, low two bits ignored
    input  logic [ROM_ADDR_W-1:0] addr,
    output rt_pkg::word_t         data
);
    timeunit 1ns;
    timeprecision 100ps;
    import rt_pkg::*;

    localparam int DEPTH = 2 ** (ROM_ADDR_W - 2);

    // filled by the testbench before and between loads
    word_t mem [0:DEPTH-1];

    initial begin
        data = '0;
    end

    // one cycle of read latency
    always @(posedge clk) begin
        data <= mem[addr[ROM_ADDR_W-1:2]];
    end

endmodule

/* dv/tb_rt_reader.sv */
module tb_rt_reader;
    timeunit 1ns;
    timeprecision 100ps;
    import rt_pkg::*;
    import apb_pkg::*;

    localparam int ROM_ADDR_W = 12;
    localparam int ROM_WORDS  = 2 ** (ROM_ADDR_W - 2);
    localparam int N_HOSTS    = 5;
    localparam int MAX_SW     = 3;
    // byte offset of the switch header
    localparam int SW_BASE    = int'(HEADER_BYTES) + N_HOSTS * int'(HOST_ENTRY_BYTES);
    // about 120 bus accesses of 3 cycles each, plus a wide margin
    localparam int MAX_CYCLES = 4000;

    logic                  clk;
    logic                  rst_n;
    apb_req_t              apb_req;
    apb_rsp_t              apb_rsp;
    logic                  pready;
    logic [ROM_ADDR_W-1:0] mem_addr;
    word_t                 mem_data;
    word_t                 img [0:ROM_WORDS-1];
    int                    seed;
    int                    cycles;

    rt_reader_top #(
        .ROM_ADDR_W (ROM_ADDR_W)
    ) dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .pready   (pready),
        .mem_addr (mem_addr),
        .mem_data (mem_data)
    );

    rt_rom_model #(
        .ROM_ADDR_W (ROM_ADDR_W)
    ) rom_i (
        .clk  (clk),
        .addr (mem_addr),
        .data (mem_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // ====================
    // helpers
    // ====================
    task automatic report_error(input string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic expect_eq(input string what, input word_t got, input word_t exp);
        assert (got === exp)
            else report_error($sformatf("%s read %h, expected %h", what, got, exp));
    endtask

    // setup phase, access phase, sample mid-cycle of the access phase
    task automatic bus_access(input logic wr, input apb_addr_t addr, input word_t wdata,
                              input logic exp_err, output word_t rdata);
        logic err;
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        assert (pready === 1'b1)
            else report_error("pready low in the access phase");
        assert (err === exp_err)
            else report_error($sformatf("pslverr %b at offset %h", err, addr));
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic write_reg(input apb_addr_t addr, input word_t data, input logic exp_err);
        word_t rd_ignored;
        bus_access(1'b1, addr, data, exp_err, rd_ignored);
    endtask

    task automatic read_reg(input apb_addr_t addr, input logic exp_err, output word_t data);
        bus_access(1'b0, addr, '0, exp_err, data);
    endtask

    // until not busy and one of the mask bits is set
    task automatic poll_status(input word_t mask, output word_t status);
        do begin
            read_reg(REG_STATUS, 1'b0, status);
        end while (status[0] || (status & mask) == '0);
    endtask

    function automatic int host_word(input int i);
        return (int'(HEADER_BYTES) + i * int'(HOST_ENTRY_BYTES)) / 4;
    endfunction

    function automatic int path_word(input int s, input int d);
        return (SW_BASE + int'(HEADER_BYTES)
                + (s * (MAX_SW + 1) + d) * int'(PATH_ENTRY_BYTES)) / 4;
    endfunction

    // ====================
    // routing image
    // ====================
    task automatic build_image();
        int p;
        for (int k = 0; k < ROM_WORDS; k++) begin
            img[k] = 32'h5A00_0000 | 32'(k);
        end
        img[0] = HOST_MAGIC;
        img[1] = N_HOSTS;
        img[2] = $random(seed);
        img[3] = $random(seed);
        for (int i = 0; i < N_HOSTS; i++) begin
            for (int j = 0; j < 8; j++) begin
                img[host_word(i) + j] = $random(seed);
            end
        end
        img[SW_BASE / 4]     = SWCH_MAGIC;
        img[SW_BASE / 4 + 1] = MAX_SW + 1;
        img[SW_BASE / 4 + 2] = MAX_SW;
        img[SW_BASE / 4 + 3] = $random(seed);
        for (int s = 0; s <= MAX_SW; s++) begin
            for (int d = 0; d <= MAX_SW; d++) begin
                p = path_word(s, d);
                for (int j = 0; j < 4; j++) begin
                    img[p + j] = $random(seed);
                end
                // one entry without a route
                if (s == 1 && d == 2) begin
                    img[p][7:0] = 8'h00;
                end else begin
                    img[p][0] = 1'b1;
                end
            end
        end
    endtask

    task automatic load_rom();
        for (int k = 0; k < ROM_WORDS; k++) begin
            rom_i.mem[k] = img[k];
        end
    endtask

    task automatic check_host(input int i);
        word_t r;
        word_t w3;
        w3 = img[host_word(i) + 3];
        read_reg(REG_HOST_IP, 1'b0, r);
        expect_eq("host ip", r, img[host_word(i)]);
        read_reg(REG_HOST_SWITCH, 1'b0, r);
        expect_eq("host switch", r, img[host_word(i) + 1]);
        read_reg(REG_HOST_PORT_QP, 1'b0, r);
        expect_eq("host port/qp", r, {w3[31:16], w3[15:0]});
    endtask

    task automatic check_path(input int s, input int d);
        word_t r;
        word_t w0;
        int    p;
        p  = path_word(s, d);
        w0 = img[p];
        write_reg(REG_QUERY, word_t'((d << 12) | (s << 8)), 1'b0);
        write_reg(REG_CTRL, 32'h4, 1'b0);
        poll_status(32'h30, r);
        expect_eq("status after path query", r, 32'h12);
        read_reg(REG_PATH_W0, 1'b0, r);
        expect_eq("path word 0", r, {w0[31:16], w0[15:8], 7'd0, w0[7:0] != 8'h00});
        read_reg(REG_PATH_W1, 1'b0, r);
        expect_eq("path word 1", r, {img[p + 1][31:16], img[p + 1][15:0]});
        read_reg(REG_PATH_NH_IP, 1'b0, r);
        expect_eq("path next hop ip", r, img[p + 2]);
        read_reg(REG_PATH_W3, 1'b0, r);
        expect_eq("path word 3", r, {img[p + 3][31:16], img[p + 3][15:0]});
    endtask

    // ====================
    // test sequence
    // ====================
    initial begin
        word_t r;
        seed    = 94;
        cycles  = 0;
        clk     = 1'b0;
        rst_n   = 1'b0;
        apb_req = '0;
        build_image();
        load_rom();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // reset state and bus errors
        read_reg(REG_STATUS, 1'b0, r);
        expect_eq("status after reset", r, 32'h0);
        read_reg(8'h30, 1'b1, r);
        write_reg(REG_HOST_COUNT, 32'h1, 1'b1);

        write_reg(REG_CTRL, 32'h1, 1'b0);
        poll_status(32'h6, r);
        expect_eq("status after load", r, 32'h2);
        read_reg(REG_HOST_COUNT, 1'b0, r);
        expect_eq("host count", r, N_HOSTS);
        read_reg(REG_MAX_SWITCH, 1'b0, r);
        expect_eq("max switch id", r, MAX_SW);

        for (int i = 0; i < N_HOSTS; i++) begin
            write_reg(REG_QUERY, word_t'(i), 1'b0);
            write_reg(REG_CTRL, 32'h2, 1'b0);
            poll_status(32'h28, r);
            expect_eq("status after host query", r, 32'h0A);
            check_host(i);
        end

        check_path(0, 0);
        check_path(1, 2);
        check_path(2, 3);
        check_path(3, 1);
        check_path(3, 3);

        // index past the table keeps the results of the last hit
        write_reg(REG_QUERY, word_t'(N_HOSTS), 1'b0);
        write_reg(REG_CTRL, 32'h2, 1'b0);
        poll_status(32'h28, r);
        expect_eq("status after host miss", r, 32'h22);
        check_host(N_HOSTS - 1);

        // bad switch magic
        img[SW_BASE / 4] = SWCH_MAGIC ^ 32'h0000_0100;
        load_rom();
        write_reg(REG_CTRL, 32'h1, 1'b0);
        poll_status(32'h6, r);
        expect_eq("status after corrupt load", r, 32'h4);
        write_reg(REG_QUERY, 32'h0000_1100, 1'b0);
        write_reg(REG_CTRL, 32'h4, 1'b0);
        poll_status(32'h30, r);
        expect_eq("status after path query without tables", r, 32'h24);

        $display("Simulation passed");
        $finish;
    end

endmodule

/* list.f */
rtl/rt_pkg.sv
rtl/apb_pkg.sv
rtl/rt_word_reader.sv
rtl/rt_table_walker.sv
rtl/rt_regs.sv
rtl/rt_reader_top.sv
dv/rt_rom_model.sv
dv/tb_rt_reader.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the routing table reader testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --timing --timescale 1ns/100ps -Wno-fatal \
    --top-module tb_rt_reader -f list.f -o sim_rt_reader > build.log 2>&1 \
    && ./obj_dir/sim_rt_reader > sim.log 2>&1 \
    || echo "build or simulation ended with an error, see build.log and sim.log"

grep -q "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
